//--- source/fetchPkg.sv
`default_nettype none

package fetchPkg;

    // Line geometry and ROM size
    localparam int lineWords = 4;
    localparam int romWords = 32;
    localparam int idWidth = 4;

    typedef logic [31:0] tWord;

    // Line request from the sequencer
    typedef struct packed {
        logic valid;
        logic [idWidth-1:0] id;
        logic [31:0] addr;
    } tLineReq;

    // Line response, word address of slot 0 kept for the pc
    typedef struct packed {
        logic valid;
        logic [idWidth-1:0] id;
        logic [29:0] wordAddr;
        tWord [lineWords-1:0] words;
    } tLineRsp;

    // R layout, also gives the I immediate from funct7 and rs2
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } tRView;

    // S layout, also gives the B immediate
    typedef struct packed {
        logic [6:0] immHigh;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLow;
        logic [6:0] opcode;
    } tSView;

    // Same word, two decodings
    typedef union packed {
        tRView rView;
        tSView sView;
    } tInstrFmt;

    typedef enum logic [2:0] {
        alu,
        aluImm,
        load,
        store,
        branch,
        jump,
        system,
        unknown
    } tInstrClass;

    typedef struct packed {
        logic valid;
        tInstrClass cls;
        logic isEbreak;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic usesRs2;
        logic [31:0] imm;
    } tPredecode;

    typedef struct packed {
        logic valid;
        logic [idWidth-1:0] id;
        logic [31:0] pc;
        tPredecode [lineWords-1:0] slots;
        logic endsProgram;
    } tBundle;

endpackage

`default_nettype wire

//--- source/fetchSequencer.sv
`default_nettype none

module fetchSequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 redirect,
    input  logic [31:0]          redirectAddr,
    input  logic                 run,
    input  logic                 haltStrobe,
    output fetchPkg::tLineReq    lineReq
);

    // Address of the next line and id of the next request
    logic [31:0] fetchAddr;
    logic [fetchPkg::idWidth-1:0] nextId;
    // Sticky stop after EBREAK, only a redirect clears it
    logic stopped;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchAddr <= '0;
            nextId <= '0;
            stopped <= 1'b0;
            lineReq <= '0;
        end else begin
            // One-cycle strobe by default
            lineReq.valid <= 1'b0;
            if (redirect) begin
                // New stream, first request next cycle
                fetchAddr <= redirectAddr;
                stopped <= 1'b0;
            end else if (haltStrobe) begin
                // Halt takes effect at once, no request this cycle
                stopped <= 1'b1;
            end else if (run && !stopped) begin
                lineReq.valid <= 1'b1;
                lineReq.id <= nextId;
                lineReq.addr <= fetchAddr;
                // Next line is 16 bytes on
                fetchAddr <= fetchAddr + 32'd16;
                nextId <= nextId + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/instrRom.sv
`default_nettype none

module instrRom #(
    parameter int latency = 2
) (
    input  logic                 clk,
    input  fetchPkg::tLineReq    lineReq,
    output fetchPkg::tLineRsp    lineRsp
);

    localparam int idxWidth = $clog2(fetchPkg::romWords);

    // Program image
    fetchPkg::tWord rom [fetchPkg::romWords];

    initial begin
        $readmemh("program.hex", rom);
    end

    // Word index wraps at the ROM size through truncation
    function automatic logic [idxWidth-1:0] romIndex(
        input logic [31:0] addr,
        input int w
    );
        romIndex = addr[2 +: idxWidth] + idxWidth'(w);
    endfunction

    // Response pipeline, stage 0 is the lookup itself
    fetchPkg::tLineRsp rspPipe [latency];

    always_ff @(posedge clk) begin
        rspPipe[0].valid <= lineReq.valid;
        rspPipe[0].id <= lineReq.id;
        rspPipe[0].wordAddr <= lineReq.addr[31:2];
        // Unaligned start reads the following words
        for (int w = 0; w < fetchPkg::lineWords; w++) begin
            rspPipe[0].words[w] <= rom[romIndex(lineReq.addr, w)];
        end
    end

    // Remaining delay stages
    for (genvar i = 1; i < latency; i++) begin : gRspPipe
        always_ff @(posedge clk) begin
            rspPipe[i] <= rspPipe[i-1];
        end
    end

    // Last stage is the response
    assign lineRsp = rspPipe[latency-1];

endmodule

`default_nettype wire

//--- source/preDecoder.sv
`default_nettype none

module preDecoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wordValid,
    input  fetchPkg::tInstrFmt   word,
    output fetchPkg::tPredecode  info
);

    fetchPkg::tPredecode nextInfo;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;

    // I form sits where funct7 and rs2 are in the R layout
    assign immI = {{20{word.rView.funct7[6]}}, word.rView.funct7, word.rView.rs2};
    // S form from the split fields
    assign immS = {{20{word.sView.immHigh[6]}}, word.sView.immHigh, word.sView.immLow};
    // B form reshuffles the same S fields
    assign immB = {{19{word.sView.immHigh[6]}}, word.sView.immHigh[6], word.sView.immLow[0],
                   word.sView.immHigh[5:0], word.sView.immLow[4:1], 1'b0};

    always_comb begin
        nextInfo.valid = wordValid;
        nextInfo.isEbreak = (word == 32'h00100073);
        nextInfo.rd = word.rView.rd;
        nextInfo.rs1 = word.rView.rs1;
        nextInfo.rs2 = word.rView.rs2;
        nextInfo.usesRs2 = 1'b0;
        nextInfo.imm = '0;
        // Class from the opcode alone
        case (word.rView.opcode)
            7'b0110011: begin
                nextInfo.cls = fetchPkg::alu;
                nextInfo.usesRs2 = 1'b1;
            end
            7'b0010011: begin
                nextInfo.cls = fetchPkg::aluImm;
                nextInfo.imm = immI;
            end
            7'b0000011: begin
                nextInfo.cls = fetchPkg::load;
                nextInfo.imm = immI;
            end
            7'b0100011: begin
                // No destination register
                nextInfo.cls = fetchPkg::store;
                nextInfo.usesRs2 = 1'b1;
                nextInfo.rd = '0;
                nextInfo.imm = immS;
            end
            7'b1100011: begin
                nextInfo.cls = fetchPkg::branch;
                nextInfo.usesRs2 = 1'b1;
                nextInfo.rd = '0;
                nextInfo.imm = immB;
            end
            // JAL keeps a zero immediate
            7'b1101111: nextInfo.cls = fetchPkg::jump;
            7'b1100111: begin
                // JALR
                nextInfo.cls = fetchPkg::jump;
                nextInfo.imm = immI;
            end
            7'b1110011: begin
                nextInfo.cls = fetchPkg::system;
                nextInfo.imm = immI;
            end
            default: nextInfo.cls = fetchPkg::unknown;
        endcase
    end

    // One register stage, only the valid is reset
    always_ff @(posedge clk) begin
        info <= nextInfo;
        if (rst) begin
            info.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/bundleCollector.sv
`default_nettype none

module bundleCollector (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      redirect,
    input  fetchPkg::tPredecode [fetchPkg::lineWords-1:0] slotInfo,
    input  logic [fetchPkg::idWidth-1:0]              rspId,
    input  logic [31:0]                               rspPc,
    output fetchPkg::tBundle                          bundle,
    output logic                                      haltStrobe,
    output logic                                      halted
);

    fetchPkg::tBundle nextBundle;
    logic cut;
    // Bundles emitted so far
    logic [31:0] bundleCount;

    // Drop every slot after the first EBREAK
    always_comb begin
        cut = 1'b0;
        nextBundle.id = rspId;
        nextBundle.pc = rspPc;
        for (int w = 0; w < fetchPkg::lineWords; w++) begin
            nextBundle.slots[w] = slotInfo[w];
            if (cut) begin
                nextBundle.slots[w].valid = 1'b0;
            end
            if (slotInfo[w].valid && slotInfo[w].isEbreak) begin
                cut = 1'b1;
            end
        end
        nextBundle.endsProgram = cut;
        // Nothing leaves while halting or halted
        nextBundle.valid = slotInfo[0].valid && !halted && !haltStrobe;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bundle <= '0;
            haltStrobe <= 1'b0;
            halted <= 1'b0;
            bundleCount <= '0;
        end else begin
            bundle <= nextBundle;
            // Pulses together with the halting bundle
            haltStrobe <= nextBundle.valid && nextBundle.endsProgram;
            if (redirect) begin
                halted <= 1'b0;
            end else if (haltStrobe) begin
                halted <= 1'b1;
            end
            if (nextBundle.valid) begin
                bundleCount <= bundleCount + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/fetchTop.sv
`default_nettype none

module fetchTop #(
    parameter int latency = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 redirect,
    input  logic [31:0]          redirectAddr,
    input  logic                 run,
    output fetchPkg::tBundle     bundle,
    output logic                 halted
);

    fetchPkg::tLineReq lineReq;
    fetchPkg::tLineRsp lineRsp;
    fetchPkg::tPredecode [fetchPkg::lineWords-1:0] slotInfo;
    logic haltStrobe;
    // Id and pc delayed to line up with the predecoder outputs
    logic [fetchPkg::idWidth-1:0] rspIdQ;
    logic [31:0] rspPcQ;

    fetchSequencer fetchSequencer_inst (
        .clk(clk),
        .rst(rst),
        .redirect(redirect),
        .redirectAddr(redirectAddr),
        .run(run),
        .haltStrobe(haltStrobe),
        .lineReq(lineReq)
    );

    instrRom #(.latency(latency)) instrRom_inst (
        .clk(clk),
        .lineReq(lineReq),
        .lineRsp(lineRsp)
    );

    // One predecoder per slot
    for (genvar w = 0; w < fetchPkg::lineWords; w++) begin : gSlot
        preDecoder preDecoder_inst (
            .clk(clk),
            .rst(rst),
            .wordValid(lineRsp.valid),
            .word(lineRsp.words[w]),
            .info(slotInfo[w])
        );
    end

    always_ff @(posedge clk) begin
        rspIdQ <= lineRsp.id;
        rspPcQ <= {lineRsp.wordAddr, 2'b00};
    end

    bundleCollector bundleCollector_inst (
        .clk(clk),
        .rst(rst),
        .redirect(redirect),
        .slotInfo(slotInfo),
        .rspId(rspIdQ),
        .rspPc(rspPcQ),
        .bundle(bundle),
        .haltStrobe(haltStrobe),
        .halted(halted)
    );

endmodule

`default_nettype wire

//--- sim/fetchTop_assert.sv
`default_nettype none

module fetchTopAssert #(
    parameter int latency = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  fetchPkg::tLineReq    lineReq,
    input  fetchPkg::tBundle     bundle,
    input  logic                 haltStrobe,
    input  logic                 halted,
    input  logic [31:0]          bundleCount
);
    timeunit 1ns;
    timeprecision 100ps;

    // Failed assertion count that the testbench reads
    int failCount = 0;
    // Request strobes delayed so bit latency+1 lines up with the bundle
    logic [latency+1:0] reqPipe;
    // Requests issued since reset
    logic [31:0] reqCount;

    always_ff @(posedge clk) begin
        if (rst) begin
            reqPipe <= '0;
            reqCount <= '0;
        end else begin
            reqPipe <= {reqPipe[latency:0], lineReq.valid};
            if (lineReq.valid) begin
                reqCount <= reqCount + 32'd1;
            end
        end
    end

    // Every request gives a bundle unless a halt dropped it
    bundleFollowsRequest: assert property (@(posedge clk) disable iff (rst)
        reqPipe[latency+1] |-> (bundle.valid || halted))
    else begin
        $error("no bundle latency+2 cycles after a line request");
        failCount++;
    end

    noBundleWhileHalted: assert property (@(posedge clk) disable iff (rst)
        !(bundle.valid && halted))
    else begin
        $error("bundle.valid high while halted");
        failCount++;
    end

    // Halt pulse only with the bundle that ends the program
    haltWithEndBundle: assert property (@(posedge clk) disable iff (rst)
        haltStrobe |-> (bundle.valid && bundle.endsProgram))
    else begin
        $error("haltStrobe without a valid endsProgram bundle");
        failCount++;
    end

    // Emitted bundles never outnumber the requests
    bundlesWithinRequests: assert property (@(posedge clk) disable iff (rst)
        bundleCount <= reqCount)
    else begin
        $error("bundle count of the collector above the number of line requests");
        failCount++;
    end

    quietAfterReset: assert property (@(posedge clk) rst |=> !bundle.valid)
    else begin
        $error("bundle.valid high in the cycle after reset");
        failCount++;
    end

endmodule

bind fetchTop fetchTopAssert #(.latency(latency)) fetchTopAssert_inst (
    .clk(clk),
    .rst(rst),
    .lineReq(lineReq),
    .bundle(bundle),
    .haltStrobe(haltStrobe),
    .halted(halted),
    .bundleCount(bundleCollector_inst.bundleCount)
);

`default_nettype wire

//--- sim/fetchTb.sv
`default_nettype none

module fetchTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int latency = 2;
    localparam int clkPeriod = 8;
    // Phase lengths in cycles
    localparam int resetCycles = 4;
    localparam int idleCycles = 10;
    localparam int firstBurst = 3;
    localparam int gapCycles = 6;
    localparam int haltWaitMax = 40;
    localparam int settleCycles = 12;
    localparam int randomBurst = 4;
    localparam int drainMax = 20;
    localparam int plannedCycles = resetCycles + idleCycles + firstBurst + gapCycles
        + haltWaitMax + settleCycles + randomBurst + drainMax + 8;

    logic clk;
    logic rst;
    logic redirect;
    logic [31:0] redirectAddr;
    logic run;
    fetchPkg::tBundle bundle;
    logic halted;

    // Reference model state
    fetchPkg::tWord progImage [fetchPkg::romWords];
    fetchPkg::tBundle expQ [$];
    fetchPkg::tBundle expBundle;
    logic [31:0] modelAddr = '0;
    logic [fetchPkg::idWidth-1:0] modelId = '0;
    logic modelStopped = 1'b0;
    int haltsHandled = 0;
    // Counters
    int haltCount = 0;
    int requestCount = 0;
    int bundleCount = 0;
    int droppedCount = 0;
    int errorCount = 0;
    logic runEnded = 1'b0;
    int seed = 32'h91fa;

    fetchTop #(.latency(latency)) fetchTop_inst (
        .clk(clk),
        .rst(rst),
        .redirect(redirect),
        .redirectAddr(redirectAddr),
        .run(run),
        .bundle(bundle),
        .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        $readmemh("program.hex", progImage);
    end

    task automatic reportFailure(input string msg);
        errorCount++;
        runEnded = 1'b1;
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    // Predecode straight from the raw bits
    function automatic fetchPkg::tPredecode decodeWord(input logic [31:0] instr);
        fetchPkg::tPredecode p;
        p = '0;
        p.valid = 1'b1;
        p.isEbreak = (instr == 32'h00100073);
        p.rd = instr[11:7];
        p.rs1 = instr[19:15];
        p.rs2 = instr[24:20];
        p.cls = fetchPkg::unknown;
        case (instr[6:0])
            7'h33: begin
                p.cls = fetchPkg::alu;
                p.usesRs2 = 1'b1;
            end
            7'h13: begin
                p.cls = fetchPkg::aluImm;
                p.imm = {{20{instr[31]}}, instr[31:20]};
            end
            7'h03: begin
                p.cls = fetchPkg::load;
                p.imm = {{20{instr[31]}}, instr[31:20]};
            end
            7'h23: begin
                p.cls = fetchPkg::store;
                p.usesRs2 = 1'b1;
                p.rd = '0;
                p.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            7'h63: begin
                p.cls = fetchPkg::branch;
                p.usesRs2 = 1'b1;
                p.rd = '0;
                p.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            7'h6f: p.cls = fetchPkg::jump;
            7'h67: begin
                p.cls = fetchPkg::jump;
                p.imm = {{20{instr[31]}}, instr[31:20]};
            end
            7'h73: begin
                p.cls = fetchPkg::system;
                p.imm = {{20{instr[31]}}, instr[31:20]};
            end
            default: p.cls = fetchPkg::unknown;
        endcase
        return p;
    endfunction

    // Whole line from a byte address with words wrapping at the ROM end
    function automatic fetchPkg::tBundle predictBundle(
        input logic [31:0] addr,
        input logic [fetchPkg::idWidth-1:0] id
    );
        fetchPkg::tBundle b;
        logic cut;
        int idx;
        b = '0;
        cut = 1'b0;
        b.valid = 1'b1;
        b.id = id;
        b.pc = {addr[31:2], 2'b00};
        for (int w = 0; w < fetchPkg::lineWords; w++) begin
            idx = int'(((addr >> 2) + 32'(w)) % 32'(fetchPkg::romWords));
            b.slots[w] = decodeWord(progImage[idx]);
            b.slots[w].valid = !cut;
            if (b.slots[w].isEbreak) begin
                cut = 1'b1;
            end
        end
        b.endsProgram = cut;
        return b;
    endfunction

    task automatic checkField(input string name, input logic [31:0] expVal,
                              input logic [31:0] gotVal);
        assert (expVal === gotVal)
        else reportFailure($sformatf("mismatch %s expected %h got %h", name, expVal, gotVal));
    endtask

    task automatic compareBundle(input fetchPkg::tBundle expB, input fetchPkg::tBundle gotB);
        checkField("bundle.id", 32'(expB.id), 32'(gotB.id));
        checkField("bundle.pc", expB.pc, gotB.pc);
        checkField("bundle.endsProgram", 32'(expB.endsProgram), 32'(gotB.endsProgram));
        for (int w = 0; w < fetchPkg::lineWords; w++) begin
            checkField($sformatf("bundle.slots[%0d].valid", w),
                       32'(expB.slots[w].valid), 32'(gotB.slots[w].valid));
            // Fields of cut slots are don't care
            if (expB.slots[w].valid) begin
                checkField($sformatf("bundle.slots[%0d].cls", w),
                           32'(expB.slots[w].cls), 32'(gotB.slots[w].cls));
                checkField($sformatf("bundle.slots[%0d].isEbreak", w),
                           32'(expB.slots[w].isEbreak), 32'(gotB.slots[w].isEbreak));
                checkField($sformatf("bundle.slots[%0d].rd", w),
                           32'(expB.slots[w].rd), 32'(gotB.slots[w].rd));
                checkField($sformatf("bundle.slots[%0d].rs1", w),
                           32'(expB.slots[w].rs1), 32'(gotB.slots[w].rs1));
                checkField($sformatf("bundle.slots[%0d].rs2", w),
                           32'(expB.slots[w].rs2), 32'(gotB.slots[w].rs2));
                checkField($sformatf("bundle.slots[%0d].usesRs2", w),
                           32'(expB.slots[w].usesRs2), 32'(gotB.slots[w].usesRs2));
                checkField($sformatf("bundle.slots[%0d].imm", w),
                           expB.slots[w].imm, gotB.slots[w].imm);
            end
        end
    endtask

    // Sequencer model on the same edge as the DUT
    always @(posedge clk) begin
        // Halt seen by the checker stops further requests
        if (haltCount != haltsHandled) begin
            modelStopped = 1'b1;
            haltsHandled = haltCount;
        end
        if (rst) begin
            modelAddr = '0;
            modelId = '0;
            modelStopped = 1'b0;
        end else if (redirect) begin
            modelAddr = redirectAddr;
            modelStopped = 1'b0;
        end else if (run && !modelStopped) begin
            expQ.push_back(predictBundle(modelAddr, modelId));
            modelAddr = modelAddr + 32'd16;
            modelId = modelId + 1'b1;
            requestCount++;
        end
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        assert (fetchTop_inst.fetchTopAssert_inst.failCount == 0)
        else reportFailure("a concurrent assertion in fetchTopAssert failed");
        if (!rst && bundle.valid) begin
            assert (expQ.size() != 0)
            else reportFailure("bundle.valid high with no line request outstanding");
            expBundle = expQ.pop_front();
            compareBundle(expBundle, bundle);
            bundleCount++;
            if (expBundle.endsProgram) begin
                // Lines still in flight die with the halt
                droppedCount += expQ.size();
                expQ.delete();
                haltCount++;
            end
        end
    end

    task automatic waitCycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic issueRedirect(input logic [31:0] addr);
        redirect = 1'b1;
        redirectAddr = addr;
        @(negedge clk);
        redirect = 1'b0;
    endtask

    task automatic runFor(input int n);
        run = 1'b1;
        repeat (n) @(negedge clk);
        run = 1'b0;
    endtask

    initial begin
        int wordIdx;
        int waited;
        rst = 1'b1;
        redirect = 1'b0;
        redirectAddr = '0;
        run = 1'b0;
        repeat (resetCycles) @(negedge clk);
        rst = 1'b0;

        // Idle with run low
        waitCycles(idleCycles);
        assert (bundleCount == 0 && halted == 1'b0)
        else reportFailure("bundle or halted seen while idle after reset");

        // Aligned stream from 0 with a gap
        issueRedirect(32'h0);
        runFor(firstBurst);
        waitCycles(gapCycles);

        // Fetch on until the EBREAK line
        run = 1'b1;
        waited = 0;
        while (!halted && waited < haltWaitMax) begin
            @(negedge clk);
            waited++;
        end
        assert (halted)
        else reportFailure("halted did not rise after the EBREAK line");
        waitCycles(settleCycles);
        assert (halted && haltCount == 1)
        else reportFailure("halt state lost or EBREAK bundle missing");
        run = 1'b0;

        // Unaligned restart near the ROM end wraps in the first line
        wordIdx = 29 + int'({$random(seed)} % 3);
        issueRedirect(32'(wordIdx) << 2);
        assert (!halted)
        else reportFailure("halted still high after a redirect");
        runFor(randomBurst);

        waited = 0;
        while (expQ.size() != 0 && waited < drainMax) begin
            @(negedge clk);
            waited++;
        end
        waitCycles(4);
        assert (expQ.size() == 0)
        else reportFailure("expected bundles never arrived");
        // Collector count against requests that were not dropped
        checkField("bundleCount", 32'(requestCount - droppedCount),
                   fetchTop_inst.bundleCollector_inst.bundleCount);

        runEnded = 1'b1;
        if (errorCount == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "errors found");
        end
    end

    // Watchdog over all phases plus margin
    initial begin
        #((plannedCycles + 50) * clkPeriod);
        reportFailure("watchdog timeout, the run did not finish in time");
    end

    // Run stopped by an assertion without reaching either end
    final begin
        if (!runEnded) begin
            $display("Something failed");
        end
    end

endmodule

`default_nettype wire

//--- all.f
source/fetchPkg.sv
source/fetchSequencer.sv
source/instrRom.sv
source/preDecoder.sv
source/bundleCollector.sv
source/fetchTop.sv
sim/fetchTop_assert.sv
sim/fetchTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module fetchTb \
    -Mdir obj_dir -o fetchSim
./obj_dir/fetchSim > sim.log 2>&1 || true
cat sim.log
if grep -q "Everything OK" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

//--- program.hex
// One 32-bit instruction word per line, ROM entries 0 to 31 in order
00500093
ffd00113
002081b3
40118233
00802283
ffc0a303
00512623
fe61ac23
00208863
fe419c63
020000ef
00008067
123453b7
00001417
00000073
c00024f3
7ff4c513
009565b3
00158603
00c001a3
00064263
00000013
00100073
00100693
00d68733
00e02023
00002783
fee7d8e3
fff7f813
00381893
ff181f23
0ff0000f
